/* rtl/calc_defines.svh */
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// datapath width, entries and results alike
`define CALC_WIDTH      16

// pressed cycles needed before a key counts
`define DEBOUNCE_CYCLES 10

// operator codes carried on operator_input and pending_op
`define OP_NONE         3'b000  // digit, equal or nothing pending
`define OP_NEG          3'b001  // key D, applied at once
`define OP_ADD          3'b010  // key A
`define OP_SUB          3'b011  // key B
`define OP_MUL          3'b100  // key C

`endif

/* rtl/calc_pkg.sv */
`include "calc_defines.svh"

package calc_pkg;

    // keypad position, row * 4 + column
    typedef logic [3:0] key_code_t;

    // decimal digit, only 0..9 ever used
    typedef logic [3:0] digit_t;

    // operator code, see OP_* macros
    typedef logic [2:0] op_code_t;

    // two's complement entry or result
    typedef logic signed [`CALC_WIDTH-1:0] value_t;

    // keypad scanner
    typedef enum logic [2:0] {
        IDLE,          // one cycle pause between scans
        SCAN_COL,      // walk the columns
        WAIT_STABLE,   // debounce count
        CONFIRM,       // key offered to controller
        WAIT_RELEASE   // hold until all rows high
    } scan_state_t;

    // key acknowledge sequence in the controller
    typedef enum logic [1:0] {
        WAIT_KEY,      // idle, watching read_input
        ACK,           // key_read high this cycle
        WAIT_DROP      // wait for read_input to fall
    } ctrl_state_t;

endpackage

/* rtl/calc_alu.sv */
`timescale 1ns/1ns
`include "calc_defines.svh"

module calc_alu (
    input  calc_pkg::value_t   a,         // accumulator
    input  calc_pkg::value_t   b,         // current entry
    input  calc_pkg::op_code_t op,
    output calc_pkg::value_t   result,    // low CALC_WIDTH bits
    output logic               overflow   // true result out of range
);

    localparam int W = `CALC_WIDTH;

    logic signed [W:0]     sum;   // one guard bit
    logic signed [W:0]     diff;
    logic signed [2*W-1:0] prod;  // full product

    // signed context, operands sign extended
    assign sum  = a + b;
    assign diff = a - b;
    assign prod = a * b;

    always_comb begin
        result   = b;
        overflow = 1'b0;
        case (op)
            `OP_ADD: begin
                result   = sum[W-1:0];
                overflow = sum[W] ^ sum[W-1];    // guard differs from sign
            end
            `OP_SUB: begin
                result   = diff[W-1:0];
                overflow = diff[W] ^ diff[W-1];
            end
            `OP_MUL: begin
                result   = prod[W-1:0];
                // upper half must be a copy of the sign bit
                overflow = (prod[2*W-1:W-1] != {(W+1){prod[W-1]}});
            end
            `OP_NONE: begin
                result   = b;  // nothing pending, pass entry
                overflow = 1'b0;
            end
            default: begin
                result   = b;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/input_control.sv */
`timescale 1ns/1ns
`include "calc_defines.svh"

module input_control (
    input  logic               clk,
    input  logic               nRST,
    input  logic [3:0]         RowIn,           // pulled up, low when pressed
    output logic [3:0]         ColOut,          // active column driven low
    output logic               read_input,      // key waiting for the controller
    input  logic               key_read,        // controller took the key
    output calc_pkg::digit_t   keypad_input,    // 0..9
    output calc_pkg::op_code_t operator_input,  // OP_* code
    output logic               equal_input      // '*' key
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES) + 1;
    localparam logic [CNT_W-1:0] DEB_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);
    localparam calc_pkg::key_code_t KEY_HASH = 4'hE;  // row 3, column 2

    calc_pkg::scan_state_t state;
    calc_pkg::scan_state_t next_state;

    logic [1:0]          col_index;      // column under test
    logic [1:0]          row_idx;        // pressed row in active column
    logic [CNT_W-1:0]    debounce_cnt;
    calc_pkg::key_code_t scan_code;      // live position of the pressed key
    calc_pkg::key_code_t key_code;       // latched on confirm
    logic                key_valid;      // some row pulled low

    assign key_valid = ~&RowIn;

    // one column low at a time
    always_comb begin
        ColOut = 4'b1111;
        ColOut[col_index] = 1'b0;
    end

    // lowest pressed row wins, so walk down and let row 0 overwrite
    always_comb begin
        row_idx = 2'd3;
        for (int r = 3; r >= 0; r--) begin
            if (!RowIn[r]) begin
                row_idx = 2'(r);
            end
        end
        scan_code = {row_idx, col_index};
    end

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::IDLE: begin
                next_state = calc_pkg::SCAN_COL;
            end
            calc_pkg::SCAN_COL: begin
                if (key_valid) begin
                    next_state = calc_pkg::WAIT_STABLE;
                end
            end
            calc_pkg::WAIT_STABLE: begin
                if (!key_valid) begin
                    next_state = calc_pkg::IDLE;  // bounce, start over
                end else if (debounce_cnt == DEB_LAST) begin
                    next_state = calc_pkg::CONFIRM;
                end
            end
            calc_pkg::CONFIRM: begin
                if (key_code == KEY_HASH || key_read) begin
                    next_state = calc_pkg::WAIT_RELEASE;  // '#' skips the exchange
                end
            end
            calc_pkg::WAIT_RELEASE: begin
                if (!key_valid) begin
                    next_state = calc_pkg::IDLE;
                end
            end
            default: begin
                next_state = calc_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= calc_pkg::IDLE;
            col_index    <= 2'd0;
            debounce_cnt <= '0;
            key_code     <= KEY_HASH;  // decodes to nothing
            read_input   <= 1'b0;
        end else begin
            state <= next_state;

            if (state == calc_pkg::SCAN_COL && !key_valid) begin
                col_index <= col_index + 2'd1;  // 3 wraps to 0
            end

            if (state == calc_pkg::WAIT_STABLE) begin
                debounce_cnt <= debounce_cnt + 1'b1;
            end else begin
                debounce_cnt <= '0;
            end

            // capture while the press is known good
            if (state == calc_pkg::WAIT_STABLE && next_state == calc_pkg::CONFIRM) begin
                key_code <= scan_code;
            end

            if (state == calc_pkg::CONFIRM && key_code != KEY_HASH) begin
                read_input <= 1'b1;
            end else if (state == calc_pkg::WAIT_RELEASE && !key_valid) begin
                read_input <= 1'b0;  // released, exchange over
            end
        end
    end

    // key position to digit, operator or equal
    always_comb begin
        keypad_input   = 4'd0;
        operator_input = `OP_NONE;
        equal_input    = 1'b0;
        case (key_code)
            4'h0: keypad_input   = 4'd1;
            4'h1: keypad_input   = 4'd2;
            4'h2: keypad_input   = 4'd3;
            4'h3: operator_input = `OP_ADD;  // A
            4'h4: keypad_input   = 4'd4;
            4'h5: keypad_input   = 4'd5;
            4'h6: keypad_input   = 4'd6;
            4'h7: operator_input = `OP_SUB;  // B
            4'h8: keypad_input   = 4'd7;
            4'h9: keypad_input   = 4'd8;
            4'hA: keypad_input   = 4'd9;
            4'hB: operator_input = `OP_MUL;  // C
            4'hC: equal_input    = 1'b1;     // '*'
            4'hD: keypad_input   = 4'd0;
            4'hF: operator_input = `OP_NEG;  // D
            default: ;                       // '#' decodes to nothing
        endcase
    end

    a_one_col_low: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~ColOut))
        else $error("ColOut %b does not have exactly one low bit", ColOut);

    // controller must never see the key vanish while it is still held
    a_drop_after_release: assert property (@(posedge clk) disable iff (!nRST)
        $fell(read_input) |-> $past(&RowIn))
        else $error("read_input fell while a row was still low");

endmodule

/* rtl/calc_controller.sv */
`timescale 1ns/1ns
`include "calc_defines.svh"

module calc_controller (
    input  logic               clk,
    input  logic               nRST,
    input  logic               read_input,      // key offered by the scanner
    output logic               key_read,        // one-cycle acknowledge
    input  calc_pkg::digit_t   keypad_input,
    input  calc_pkg::op_code_t operator_input,
    input  logic               equal_input,
    output calc_pkg::value_t   acc,             // left operand
    output calc_pkg::value_t   entry,           // value being typed
    output calc_pkg::op_code_t pending_op,      // operator waiting for its right side
    input  calc_pkg::value_t   alu_result,      // acc pending_op entry
    input  logic               alu_overflow,
    output calc_pkg::value_t   display_value,
    output logic               result_valid,    // pulse per equal key
    output logic               overflow         // flag of the last equal
);

    localparam calc_pkg::value_t RADIX = calc_pkg::value_t'(10);

    calc_pkg::ctrl_state_t state;

    // key fields are sampled on the edge that ends this cycle
    assign key_read = (state == calc_pkg::ACK);

    // display follows the entry register
    assign display_value = entry;

    // one acknowledge per rise of read_input
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= calc_pkg::WAIT_KEY;
        end else begin
            case (state)
                calc_pkg::WAIT_KEY: begin
                    if (read_input) begin
                        state <= calc_pkg::ACK;
                    end
                end
                calc_pkg::ACK: begin
                    state <= calc_pkg::WAIT_DROP;
                end
                calc_pkg::WAIT_DROP: begin
                    if (!read_input) begin
                        state <= calc_pkg::WAIT_KEY;  // key released
                    end
                end
                default: begin
                    state <= calc_pkg::WAIT_KEY;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            acc          <= '0;
            entry        <= '0;
            pending_op   <= `OP_NONE;
            result_valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            result_valid <= 1'b0;  // pulse only

            if (state == calc_pkg::ACK) begin
                if (equal_input) begin
                    // result stays on display and seeds the next entry
                    acc          <= alu_result;
                    entry        <= alu_result;
                    pending_op   <= `OP_NONE;
                    result_valid <= 1'b1;
                    overflow     <= alu_overflow;
                end else if (operator_input == `OP_NEG) begin
                    entry <= -entry;  // unary, no pending change
                end else if (operator_input != `OP_NONE) begin
                    // with nothing pending the ALU hands back entry,
                    // otherwise the previous step is folded in first
                    acc        <= alu_result;
                    pending_op <= operator_input;
                    entry      <= '0;
                end else begin
                    // decimal shift, wraps mod 2^16
                    entry <= entry * RADIX + calc_pkg::value_t'(keypad_input);
                end
            end
        end
    end

    a_single_ack: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read)
        else $error("key_read held high for more than one cycle");

endmodule

/* rtl/calc_top.sv */
`timescale 1ns/1ns

module calc_top (
    input  logic             clk,
    input  logic             nRST,
    input  logic [3:0]       RowIn,          // keypad rows, active low
    output logic [3:0]       ColOut,         // keypad columns, one low
    output calc_pkg::value_t display_value,
    output logic             result_valid,
    output logic             overflow
);

    logic               read_input;
    logic               key_read;
    logic               equal_input;
    calc_pkg::digit_t   keypad_input;
    calc_pkg::op_code_t operator_input;

    calc_pkg::value_t   acc;
    calc_pkg::value_t   entry;
    calc_pkg::op_code_t pending_op;
    calc_pkg::value_t   alu_result;
    logic               alu_overflow;

    input_control input_control_inst (
        .clk            (clk),
        .nRST           (nRST),
        .RowIn          (RowIn),
        .ColOut         (ColOut),
        .read_input     (read_input),
        .key_read       (key_read),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input)
    );

    calc_controller calc_controller_inst (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .key_read       (key_read),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .acc            (acc),
        .entry          (entry),
        .pending_op     (pending_op),
        .alu_result     (alu_result),
        .alu_overflow   (alu_overflow),
        .display_value  (display_value),
        .result_valid   (result_valid),
        .overflow       (overflow)
    );

    // acc pending_op entry, purely combinational
    calc_alu calc_alu_inst (
        .a        (acc),
        .b        (entry),
        .op       (pending_op),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

endmodule

/* bench/calc_tb.sv */
`timescale 1ns/1ns
`include "calc_defines.svh"

module calc_tb;

    localparam int HOLD_CYCLES = 120;  // scan + debounce + exchange fit easily
    localparam int IDLE_CYCLES = 20;   // gap after release
    localparam int KEY_A       = 10;   // add
    localparam int KEY_B       = 11;   // subtract
    localparam int KEY_C       = 12;   // multiply
    localparam int KEY_D       = 13;   // negate
    localparam int KEY_STAR    = 14;   // equal
    localparam int KEY_HASH    = 15;   // ignored by the DUT
    localparam int NO_OP       = -1;   // model: nothing pending
    // worst case key count over all tests
    localparam int MAX_KEYS    = 8 * 7 + 10 * 8 + 6 * 15 + 4 * 3;
    localparam longint WATCHDOG_NS = longint'(MAX_KEYS) * 140 * 40 + 100_000;

    logic             clk;
    logic             nRST;
    logic [3:0]       RowIn;
    logic [3:0]       ColOut;
    calc_pkg::value_t display_value;
    logic             result_valid;
    logic             overflow;

    logic [1:0] key_row;   // pressed key position
    logic [1:0] key_col;
    logic       key_down;

    int m_entry;           // reference calculator state
    int m_acc;
    int m_pending;
    bit m_ovf;

    int checks        = 0;
    int errors        = 0;
    int test_err_base = 0;
    int pulse_count   = 0; // result_valid pulses seen so far

    calc_top calc_top_inst (
        .clk           (clk),
        .nRST          (nRST),
        .RowIn         (RowIn),
        .ColOut        (ColOut),
        .display_value (display_value),
        .result_valid  (result_valid),
        .overflow      (overflow)
    );

    always #20 clk = ~clk;  // 40 ns period

    // matrix: row pulled low only while its column is driven low
    always_comb begin
        RowIn = 4'b1111;
        if (key_down && !ColOut[key_col]) begin
            RowIn[key_row] = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (nRST && result_valid) begin
            pulse_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the key sequence did not complete in time");
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-8s done, %0d errors", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    // sign extend the low CALC_WIDTH bits
    function automatic int wrap_value(input int v);
        logic signed [`CALC_WIDTH-1:0] t;
        t = v[`CALC_WIDTH-1:0];
        return int'(t);
    endfunction

    function automatic int row_of(input int key);
        if (key == 0 || key >= KEY_D) begin
            return 3;  // * 0 # D
        end
        if (key >= KEY_A) begin
            return key - KEY_A;  // A B C down the last column
        end
        return (key - 1) / 3;
    endfunction

    function automatic int col_of(input int key);
        case (key)
            0:                          return 1;
            KEY_STAR:                   return 0;
            KEY_HASH:                   return 2;
            KEY_A, KEY_B, KEY_C, KEY_D: return 3;
            default:                    return (key - 1) % 3;
        endcase
    endfunction

    // full precision result, overflow when wrapping changes it
    task automatic model_alu(input int a, input int b, input int op,
                             output int res, output bit ovf);
        int full;
        case (op)
            KEY_A:   full = a + b;
            KEY_B:   full = a - b;
            KEY_C:   full = a * b;
            default: full = b;  // nothing pending
        endcase
        res = wrap_value(full);
        ovf = (full != res);
    endtask

    task automatic apply_model(input int key);
        int res;
        bit ovf;
        if (key <= 9) begin
            m_entry = wrap_value(m_entry * 10 + key);
        end else if (key == KEY_D) begin
            m_entry = wrap_value(-m_entry);
        end else if (key == KEY_STAR) begin
            model_alu(m_acc, m_entry, m_pending, res, ovf);
            m_acc     = res;
            m_entry   = res;
            m_pending = NO_OP;
            m_ovf     = ovf;
        end else if (key != KEY_HASH) begin
            model_alu(m_acc, m_entry, m_pending, res, ovf);  // left to right fold
            m_acc     = res;
            m_pending = key;
            m_entry   = 0;
        end
    endtask

    task automatic press_key(input int row, input int col);
        @(posedge clk);
        key_row  <= row[1:0];
        key_col  <= col[1:0];
        key_down <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        key_down <= 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    // press, update model, compare once the outputs have settled
    task automatic enter_key(input int key);
        int pulses_before;
        pulses_before = pulse_count;
        press_key(row_of(key), col_of(key));
        apply_model(key);
        @(negedge clk);
        check_value("display_value", m_entry, display_value);
        check_value("overflow", int'(m_ovf), int'(overflow));
        check_value("result_valid pulses", (key == KEY_STAR) ? 1 : 0,
                    pulse_count - pulses_before);
    endtask

    task automatic enter_number(input int digits);
        for (int i = 0; i < digits; i++) begin
            enter_key(int'($urandom % 10));
        end
    endtask

    initial begin
        int unsigned seed_draw;
        int          len;
        seed_draw = $urandom(32'h5348_2156);  // seeds the generator
        clk       = 1'b0;
        nRST      = 1'b0;
        key_down  = 1'b0;
        key_row   = 2'd0;
        key_col   = 2'd0;
        m_entry   = 0;
        m_acc     = 0;
        m_pending = NO_OP;
        m_ovf     = 1'b0;

        @(posedge clk);
        repeat (3) @(posedge clk);  // three full cycles in reset
        nRST <= 1'b1;
        @(negedge clk);
        check_value("display_value", 0, display_value);
        check_value("result_valid", 0, int'(result_valid));
        check_value("overflow", 0, int'(overflow));
        check_value("ColOut", 4'b1110, int'(ColOut));
        end_test("reset");

        // digit entry, the last two long enough to wrap
        for (int s = 0; s < 8; s++) begin
            len = (s < 6) ? 1 + int'($urandom % 4) : 6;
            enter_number(len);
            enter_key(KEY_B);  // fresh entry for the next run
        end
        end_test("digits");

        for (int s = 0; s < 10; s++) begin
            enter_number(1 + int'($urandom % 3));
            enter_key(KEY_A + int'($urandom % 3));
            enter_number(1 + int'($urandom % 3));
            enter_key(KEY_STAR);
        end
        end_test("arith");

        // negation and operator chains
        for (int s = 0; s < 6; s++) begin
            enter_number(1 + int'($urandom % 3));
            enter_key(KEY_D);
            enter_key(KEY_A + int'($urandom % 3));
            enter_number(1 + int'($urandom % 3));
            if ($urandom % 2 == 1) begin
                enter_key(KEY_D);
            end
            enter_key(KEY_A + int'($urandom % 3));
            enter_number(1 + int'($urandom % 3));
            if ($urandom % 2 == 1) begin
                enter_key(KEY_D);
            end
            enter_key(KEY_STAR);
        end
        end_test("chain");

        // model leaves the entry alone on '#', so display must hold
        for (int s = 0; s < 4; s++) begin
            enter_number(1 + int'($urandom % 2));
            enter_key(KEY_HASH);
        end
        end_test("hash");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* calc.f */
+incdir+rtl
rtl/calc_pkg.sv
rtl/calc_alu.sv
rtl/input_control.sv
rtl/calc_controller.sv
rtl/calc_top.sv
bench/calc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f calc.f \
    --top-module calc_tb -o calc_sim > build.log 2>&1 \
    && ./obj_dir/calc_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
